//--- Bender.yml
package:
  name: ppu_video_out

sources:
  # Design sources in compile order
  - files:
      - design/ppu_pkg.sv
      - design/ppu_cfg_regs.sv
      - design/scanline_emu.sv
      - design/rgb_range_limiter.sv
      - design/ppu_video_out.sv

  # Testbench and bound checker
  - target: test
    files:
      - tb/ppu_video_out_asserts.sv
      - tb/tb_ppu_video_out.sv

//--- design/ppu_cfg_regs.sv
// Registers the configuration word and hands each output stage its decoded settings
`timescale 1ns/10ps

module ppu_cfg_regs
  import ppu_pkg::*;
(
  input  logic     VCLK_Tx,
  input  logic     nVRST_Tx,
  input  ppu_cfg_t cfg_i,
  output sl_cfg_t  vsl_cfg_o,
  output sl_cfg_t  hsl_cfg_o,
  output logic     limited_rgb_o
);

  // 4-bit strength to 8-bit multiplier, (s + 1) * 16 - 1
  function automatic logic [SL_STR_W-1:0] expand_str(input logic [3:0] str);
    return {str, 4'hf};
  endfunction

  sl_cfg_t vsl_cfg_next;
  sl_cfg_t hsl_cfg_next;

  // ==================================================
  // Decode
  // ==================================================

  always_comb begin
    hsl_cfg_next.en        = cfg_i.hsl_en;
    hsl_cfg_next.thickness = cfg_i.hsl_thickness;
    hsl_cfg_next.strength  = expand_str(cfg_i.hsl_str);

    // Vertical enable is never linked
    vsl_cfg_next.en = cfg_i.vsl_en;
    if (cfg_i.h2v_linked) begin
      vsl_cfg_next.thickness = cfg_i.hsl_thickness;
      vsl_cfg_next.strength  = expand_str(cfg_i.hsl_str);
    end else begin
      vsl_cfg_next.thickness = cfg_i.vsl_thickness;
      vsl_cfg_next.strength  = expand_str(cfg_i.vsl_str);
    end
  end

  // ==================================================
  // Output registers
  // ==================================================

  // Cleared state means scanlines off and full range
  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      vsl_cfg_o     <= '0;
      hsl_cfg_o     <= '0;
      limited_rgb_o <= 1'b0;
    end else begin
      vsl_cfg_o     <= vsl_cfg_next;
      hsl_cfg_o     <= hsl_cfg_next;
      limited_rgb_o <= cfg_i.limited_rgb;
    end
  end

endmodule

//--- design/ppu_pkg.sv
// Shared widths, video structs and scanline constants for the video output pipeline
package ppu_pkg;

  // ==================================================
  // Widths
  // ==================================================

  // Bits per colour channel
  localparam int COLOR_W = 8;

  // Relative position inside a scanline period
  localparam int POS_W = 8;

  // Expanded scanline strength
  localparam int SL_STR_W = 8;

  // ==================================================
  // Video and configuration structs
  // ==================================================

  // One pixel with its sync and DE flags
  typedef struct packed {
    logic               vsync;
    logic               hsync;
    logic               de;
    logic [COLOR_W-1:0] red;
    logic [COLOR_W-1:0] green;
    logic [COLOR_W-1:0] blue;
  } video_pixel_t;

  // Pixel position relative to the scanline period
  typedef struct packed {
    logic [POS_W-1:0] hpos_rel;
    logic [POS_W-1:0] vpos_rel;
  } sl_pos_t;

  // Ready-to-use settings of one scanline stage
  typedef struct packed {
    logic                en;
    logic [1:0]          thickness;
    logic [SL_STR_W-1:0] strength;
  } sl_cfg_t;

  // Raw configuration word as it arrives
  typedef struct packed {
    logic       hsl_en;
    logic [1:0] hsl_thickness;
    logic [3:0] hsl_str;
    logic       vsl_en;
    logic [1:0] vsl_thickness;
    logic [3:0] vsl_str;
    logic       h2v_linked;
    logic       limited_rgb;
  } ppu_cfg_t;

  // ==================================================
  // Scanline and pipeline constants
  // ==================================================

  // Threshold drops by one step per thickness level
  localparam int SL_THRESH_STEP = 64;

  // Cycles from the top inputs to the registered outputs
  localparam int PIPE_LATENCY = 7;

  // Position at or above which a pixel belongs to the dark part of the line
  function automatic logic [POS_W-1:0] sl_threshold(input logic [1:0] thickness);
    int unsigned thresh;
    thresh = 192 - thickness * SL_THRESH_STEP;
    return POS_W'(thresh);
  endfunction

endpackage

//--- design/ppu_video_out.sv
// Top of the video output half: config decode, two scanline stages and range limiting
`timescale 1ns/10ps

module ppu_video_out
  import ppu_pkg::*;
#(
  parameter int unsigned LIMIT_COEFF  = 220,
  parameter int unsigned LIMIT_OFFSET = 16
) (
  input  logic                 VCLK_Tx,
  input  logic                 nVRST_Tx,
  input  video_pixel_t         pix_i,
  input  sl_pos_t              pos_i,
  input  ppu_cfg_t             cfg_i,
  output logic                 VSYNC_o,
  output logic                 HSYNC_o,
  output logic                 DE_o,
  output logic [3*COLOR_W-1:0] VD_o
);

  sl_cfg_t      vsl_cfg;
  sl_cfg_t      hsl_cfg;
  logic         limited_rgb;
  video_pixel_t vert_pix;
  sl_pos_t      vert_pos;
  video_pixel_t horiz_pix;

  ppu_cfg_regs cfg_regs_u (
    .VCLK_Tx       (VCLK_Tx),
    .nVRST_Tx      (nVRST_Tx),
    .cfg_i         (cfg_i),
    .vsl_cfg_o     (vsl_cfg),
    .hsl_cfg_o     (hsl_cfg),
    .limited_rgb_o (limited_rgb)
  );

  // ==================================================
  // Scanline emulation
  // ==================================================

  // Vertical lines follow the horizontal position
  scanline_emu #(.USE_VPOS(1'b0)) vert_sl_u (
    .VCLK_Tx  (VCLK_Tx),
    .nVRST_Tx (nVRST_Tx),
    .pix_i    (pix_i),
    .pos_i    (pos_i),
    .sl_cfg_i (vsl_cfg),
    .pix_o    (vert_pix),
    .pos_o    (vert_pos)
  );

  scanline_emu #(.USE_VPOS(1'b1)) horiz_sl_u (
    .VCLK_Tx  (VCLK_Tx),
    .nVRST_Tx (nVRST_Tx),
    .pix_i    (vert_pix),
    .pos_i    (vert_pos),
    .sl_cfg_i (hsl_cfg),
    .pix_o    (horiz_pix),
    .pos_o    ()
  );

  rgb_range_limiter #(
    .LIMIT_COEFF  (LIMIT_COEFF),
    .LIMIT_OFFSET (LIMIT_OFFSET)
  ) limiter_u (
    .VCLK_Tx       (VCLK_Tx),
    .nVRST_Tx      (nVRST_Tx),
    .pix_i         (horiz_pix),
    .limited_rgb_i (limited_rgb),
    .VSYNC_o       (VSYNC_o),
    .HSYNC_o       (HSYNC_o),
    .DE_o          (DE_o),
    .VD_o          (VD_o)
  );

endmodule

//--- design/rgb_range_limiter.sv
// Optional limited-range RGB compression with the final registered video outputs
`timescale 1ns/10ps

module rgb_range_limiter
  import ppu_pkg::*;
#(
  parameter int unsigned LIMIT_COEFF  = 220,
  parameter int unsigned LIMIT_OFFSET = 16
) (
  input  logic                 VCLK_Tx,
  input  logic                 nVRST_Tx,
  input  video_pixel_t         pix_i,
  input  logic                 limited_rgb_i,
  output logic                 VSYNC_o,
  output logic                 HSYNC_o,
  output logic                 DE_o,
  output logic [3*COLOR_W-1:0] VD_o
);

  localparam logic [COLOR_W-1:0] COEFF  = COLOR_W'(LIMIT_COEFF);
  localparam logic [COLOR_W-1:0] OFFSET = COLOR_W'(LIMIT_OFFSET);

  logic [COLOR_W-1:0]   ch_in [3];
  logic [2*COLOR_W-1:0] prod  [3];

  // Product with bit 7 kept for rounding
  logic [COLOR_W:0]   prod_s1  [3];
  logic [COLOR_W-1:0] round_s2 [3];

  // Full-range copy and sync run alongside
  video_pixel_t pix_s1;
  video_pixel_t pix_s2;

  assign ch_in[0] = pix_i.red;
  assign ch_in[1] = pix_i.green;
  assign ch_in[2] = pix_i.blue;

  always_comb begin
    for (int i = 0; i < 3; i++) begin
      prod[i] = ch_in[i] * COEFF;
    end
  end

  // ==================================================
  // Multiply, round, offset and output registers
  // ==================================================

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      for (int i = 0; i < 3; i++) begin
        prod_s1[i]  <= '0;
        round_s2[i] <= '0;
      end
      pix_s1  <= '0;
      pix_s2  <= '0;
      VSYNC_o <= 1'b0;
      HSYNC_o <= 1'b0;
      DE_o    <= 1'b0;
      VD_o    <= '0;
    end else begin
      for (int i = 0; i < 3; i++) begin
        prod_s1[i]  <= prod[i][2*COLOR_W-1:COLOR_W-1];
        // Add the half bit, i.e. (x + 128) / 256
        round_s2[i] <= prod_s1[i][COLOR_W:1] + prod_s1[i][0];
      end
      pix_s1 <= pix_i;
      pix_s2 <= pix_s1;

      VSYNC_o <= pix_s2.vsync;
      HSYNC_o <= pix_s2.hsync;
      DE_o    <= pix_s2.de;
      if (limited_rgb_i)
        VD_o <= {round_s2[0] + OFFSET, round_s2[1] + OFFSET, round_s2[2] + OFFSET};
      else
        VD_o <= {pix_s2.red, pix_s2.green, pix_s2.blue};
    end
  end

endmodule

//--- design/scanline_emu.sv
// One scanline dimming stage, instantiated once per direction in the output pipeline
`timescale 1ns/10ps

module scanline_emu
  import ppu_pkg::*;
#(
  parameter bit USE_VPOS = 1'b0
) (
  input  logic         VCLK_Tx,
  input  logic         nVRST_Tx,
  input  video_pixel_t pix_i,
  input  sl_pos_t      pos_i,
  input  sl_cfg_t      sl_cfg_i,
  output video_pixel_t pix_o,
  output sl_pos_t      pos_o
);

  localparam int PROD_W = COLOR_W + SL_STR_W;

  logic [POS_W-1:0]   sel_pos;
  logic               dim_now;
  logic [COLOR_W-1:0] ch_in [3];
  logic [PROD_W-1:0]  prod  [3];

  // Stage one registers
  video_pixel_t       pix_s1;
  sl_pos_t            pos_s1;
  logic               dim_s1;
  logic [PROD_W-1:0]  prod_s1 [3];

  // Stage two results
  logic [COLOR_W-1:0] ch_s1  [3];
  logic [COLOR_W-1:0] ch_out [3];

  // ==================================================
  // Stage one, threshold compare and products
  // ==================================================

  assign sel_pos = USE_VPOS ? pos_i.vpos_rel : pos_i.hpos_rel;
  assign dim_now = sl_cfg_i.en && pix_i.de && (sel_pos >= sl_threshold(sl_cfg_i.thickness));

  assign ch_in[0] = pix_i.red;
  assign ch_in[1] = pix_i.green;
  assign ch_in[2] = pix_i.blue;

  always_comb begin
    for (int i = 0; i < 3; i++) begin
      prod[i] = ch_in[i] * sl_cfg_i.strength;
    end
  end

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      pix_s1 <= '0;
      pos_s1 <= '0;
      dim_s1 <= 1'b0;
      for (int i = 0; i < 3; i++) begin
        prod_s1[i] <= '0;
      end
    end else begin
      pix_s1 <= pix_i;
      pos_s1 <= pos_i;
      dim_s1 <= dim_now;
      for (int i = 0; i < 3; i++) begin
        prod_s1[i] <= prod[i];
      end
    end
  end

  // ==================================================
  // Stage two, subtract the scaled product
  // ==================================================

  assign ch_s1[0] = pix_s1.red;
  assign ch_s1[1] = pix_s1.green;
  assign ch_s1[2] = pix_s1.blue;

  // Top bits of the product are c * strength / 256
  always_comb begin
    for (int i = 0; i < 3; i++) begin
      if (dim_s1)
        ch_out[i] = ch_s1[i] - prod_s1[i][PROD_W-1 -: COLOR_W];
      else
        ch_out[i] = ch_s1[i];
    end
  end

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      pix_o <= '0;
      pos_o <= '0;
    end else begin
      pix_o.vsync <= pix_s1.vsync;
      pix_o.hsync <= pix_s1.hsync;
      pix_o.de    <= pix_s1.de;
      pix_o.red   <= ch_out[0];
      pix_o.green <= ch_out[1];
      pix_o.blue  <= ch_out[2];
      pos_o       <= pos_s1;
    end
  end

endmodule

//--- tb.f
design/ppu_pkg.sv
design/ppu_cfg_regs.sv
design/scanline_emu.sv
design/rgb_range_limiter.sv
design/ppu_video_out.sv
tb/ppu_video_out_asserts.sv
tb/tb_ppu_video_out.sv

//--- tb/ppu_video_out_asserts.sv
// Bound checker for the video output top, compares every output against the pipeline rules
`timescale 1ns/10ps

module ppu_video_out_asserts
  import ppu_pkg::*;
#(
  parameter int unsigned LIMIT_COEFF  = 220,
  parameter int unsigned LIMIT_OFFSET = 16
) (
  input logic                 VCLK_Tx,
  input logic                 nVRST_Tx,
  input video_pixel_t         pix_i,
  input sl_pos_t              pos_i,
  input ppu_cfg_t             cfg_i,
  input logic                 VSYNC_o,
  input logic                 HSYNC_o,
  input logic                 DE_o,
  input logic [3*COLOR_W-1:0] VD_o
);

  // Number of failed checks, watched by the testbench
  int unsigned fail_cnt = 0;

  // Input history, oldest entry lines up with the outputs
  video_pixel_t pix_q [PIPE_LATENCY];
  sl_pos_t      pos_q [PIPE_LATENCY];
  ppu_cfg_t     cfg_q;
  logic [3:0]   run_cnt;
  logic [3:0]   hold_cnt;
  logic         cfg_settled;

  video_pixel_t         old_pix;
  sl_pos_t              old_pos;
  logic [1:0]           v_thick;
  logic [3:0]           v_str;
  logic [3*COLOR_W-1:0] in_rgb;
  logic [3*COLOR_W-1:0] after_v;
  logic [3*COLOR_W-1:0] after_h;
  logic [3*COLOR_W-1:0] exp_vd;
  logic [3*COLOR_W-1:0] exp_linked;
  logic [2:0]           exp_sync;
  logic [2:0]           out_sync;

  // ==================================================
  // Reference arithmetic
  // ==================================================

  function automatic logic [7:0] strength_of(input logic [3:0] s);
    int unsigned sv;
    sv = s;
    return 8'((sv + 1) * 16 - 1);
  endfunction

  function automatic logic [COLOR_W-1:0] dim_channel(input logic [COLOR_W-1:0] c,
                                                    input logic [7:0] str);
    int unsigned cv;
    int unsigned sv;
    cv = c;
    sv = str;
    return COLOR_W'(cv - (cv * sv) / 256);
  endfunction

  // Dark part of the line when the position reaches the thickness threshold
  function automatic logic [3*COLOR_W-1:0] dim_rgb(input logic [3*COLOR_W-1:0] rgb,
                                                  input logic de,
                                                  input logic en,
                                                  input logic [1:0] thick,
                                                  input logic [3:0] str,
                                                  input logic [POS_W-1:0] pos);
    int         thresh;
    logic [7:0] s;
    thresh = 192 - int'(thick) * SL_THRESH_STEP;
    s = strength_of(str);
    if (en && de && int'(pos) >= thresh)
      return {dim_channel(rgb[3*COLOR_W-1 -: COLOR_W], s),
              dim_channel(rgb[2*COLOR_W-1 -: COLOR_W], s),
              dim_channel(rgb[COLOR_W-1:0], s)};
    return rgb;
  endfunction

  function automatic logic [COLOR_W-1:0] limit_channel(input logic [COLOR_W-1:0] c);
    int unsigned cv;
    cv = c;
    return COLOR_W'((cv * LIMIT_COEFF + 128) / 256 + LIMIT_OFFSET);
  endfunction

  function automatic logic [3*COLOR_W-1:0] limit_rgb(input logic [3*COLOR_W-1:0] rgb);
    return {limit_channel(rgb[3*COLOR_W-1 -: COLOR_W]),
            limit_channel(rgb[2*COLOR_W-1 -: COLOR_W]),
            limit_channel(rgb[COLOR_W-1:0])};
  endfunction

  // ==================================================
  // History and settle tracking
  // ==================================================

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      for (int i = 0; i < PIPE_LATENCY; i++) begin
        pix_q[i] <= '0;
        pos_q[i] <= '0;
      end
      cfg_q    <= '0;
      run_cnt  <= '0;
      hold_cnt <= '0;
    end else begin
      pix_q[0] <= pix_i;
      pos_q[0] <= pos_i;
      for (int i = 1; i < PIPE_LATENCY; i++) begin
        pix_q[i] <= pix_q[i-1];
        pos_q[i] <= pos_q[i-1];
      end
      cfg_q <= cfg_i;
      if (run_cnt != 4'hf)
        run_cnt <= run_cnt + 1'b1;
      if (cfg_i != cfg_q)
        hold_cnt <= '0;
      else if (hold_cnt != 4'hf)
        hold_cnt <= hold_cnt + 1'b1;
    end
  end

  // Config unchanged over the last 8 cycles and all of it seen after reset
  assign cfg_settled = (run_cnt >= 4'd8) && (hold_cnt >= 4'd7) && (cfg_i == cfg_q);

  assign old_pix  = pix_q[PIPE_LATENCY-1];
  assign old_pos  = pos_q[PIPE_LATENCY-1];
  assign in_rgb   = {old_pix.red, old_pix.green, old_pix.blue};
  assign exp_sync = {old_pix.vsync, old_pix.hsync, old_pix.de};
  assign out_sync = {VSYNC_o, HSYNC_o, DE_o};

  // Linking swaps in the h fields for the vertical stage
  assign v_thick = cfg_i.h2v_linked ? cfg_i.hsl_thickness : cfg_i.vsl_thickness;
  assign v_str   = cfg_i.h2v_linked ? cfg_i.hsl_str : cfg_i.vsl_str;

  assign after_v = dim_rgb(in_rgb, old_pix.de, cfg_i.vsl_en, v_thick, v_str, old_pos.hpos_rel);
  assign after_h = dim_rgb(after_v, old_pix.de, cfg_i.hsl_en, cfg_i.hsl_thickness,
                           cfg_i.hsl_str, old_pos.vpos_rel);
  assign exp_vd  = cfg_i.limited_rgb ? limit_rgb(after_h) : after_h;

  assign exp_linked = dim_rgb(in_rgb, old_pix.de, 1'b1, cfg_i.hsl_thickness,
                              cfg_i.hsl_str, old_pos.hpos_rel);

  // ==================================================
  // Assertions
  // ==================================================

  a_reset_clear: assert property (@(posedge VCLK_Tx)
    (!nVRST_Tx || run_cnt == 4'd0) |-> (out_sync == 3'b000 && VD_o == '0))
  else begin
    fail_cnt = fail_cnt + 1;
    $error("Error reset: expected %h actual %h", 27'h0, $sampled({out_sync, VD_o}));
  end

  a_sync_de: assert property (@(posedge VCLK_Tx) disable iff (!nVRST_Tx)
    (run_cnt >= 4'(PIPE_LATENCY)) |-> (out_sync == exp_sync))
  else begin
    fail_cnt = fail_cnt + 1;
    $error("Error sync_de: expected %b actual %b", $sampled(exp_sync), $sampled(out_sync));
  end

  a_passthrough: assert property (@(posedge VCLK_Tx) disable iff (!nVRST_Tx)
    (cfg_settled && !cfg_i.vsl_en && !cfg_i.hsl_en && !cfg_i.limited_rgb) |-> (VD_o == in_rgb))
  else begin
    fail_cnt = fail_cnt + 1;
    $error("Error passthrough: expected %h actual %h", $sampled(in_rgb), $sampled(VD_o));
  end

  a_linking: assert property (@(posedge VCLK_Tx) disable iff (!nVRST_Tx)
    (cfg_settled && cfg_i.h2v_linked && cfg_i.vsl_en && !cfg_i.hsl_en && !cfg_i.limited_rgb)
    |-> (VD_o == exp_linked))
  else begin
    fail_cnt = fail_cnt + 1;
    $error("Error linking: expected %h actual %h", $sampled(exp_linked), $sampled(VD_o));
  end

  // Dimming and range limiting in every combination
  a_video_data: assert property (@(posedge VCLK_Tx) disable iff (!nVRST_Tx)
    cfg_settled |-> (VD_o == exp_vd))
  else begin
    fail_cnt = fail_cnt + 1;
    $error("Error video_data: expected %h actual %h", $sampled(exp_vd), $sampled(VD_o));
  end

endmodule

bind ppu_video_out ppu_video_out_asserts #(
  .LIMIT_COEFF  (LIMIT_COEFF),
  .LIMIT_OFFSET (LIMIT_OFFSET)
) asserts_u (
  .VCLK_Tx  (VCLK_Tx),
  .nVRST_Tx (nVRST_Tx),
  .pix_i    (pix_i),
  .pos_i    (pos_i),
  .cfg_i    (cfg_i),
  .VSYNC_o  (VSYNC_o),
  .HSYNC_o  (HSYNC_o),
  .DE_o     (DE_o),
  .VD_o     (VD_o)
);

//--- tb/tb_ppu_video_out.sv
// Testbench for the video output top, random pixels per config phase with checks in the bound checker
`timescale 1ns/10ps

module tb_ppu_video_out
  import ppu_pkg::*;
();

  localparam int          CLK_HALF     = 50;
  localparam int          RESET_CYCLES = 4;
  localparam int          PHASE_PIXELS = 200;
  localparam int          NUM_PHASES   = 16;
  localparam int unsigned SEED         = 32'h5fc29ba2;

  // Every phase plus both resets, drain and some margin
  localparam int TIMEOUT_CYCLES = NUM_PHASES * (PHASE_PIXELS + 1) + 2 * RESET_CYCLES
                                  + PIPE_LATENCY + 50;

  logic                 VCLK_Tx;
  logic                 nVRST_Tx;
  video_pixel_t         pix_i;
  sl_pos_t              pos_i;
  ppu_cfg_t             cfg_i;
  logic                 VSYNC_o;
  logic                 HSYNC_o;
  logic                 DE_o;
  logic [3*COLOR_W-1:0] VD_o;

  int unsigned cycle_cnt = 0;

  ppu_video_out #(
    .LIMIT_COEFF  (220),
    .LIMIT_OFFSET (16)
  ) UUT (
    .VCLK_Tx  (VCLK_Tx),
    .nVRST_Tx (nVRST_Tx),
    .pix_i    (pix_i),
    .pos_i    (pos_i),
    .cfg_i    (cfg_i),
    .VSYNC_o  (VSYNC_o),
    .HSYNC_o  (HSYNC_o),
    .DE_o     (DE_o),
    .VD_o     (VD_o)
  );

  always #CLK_HALF VCLK_Tx = ~VCLK_Tx;

  // ==================================================
  // Stimulus helpers
  // ==================================================

  // Random fields with the requested enables, linking forces different v fields
  function automatic ppu_cfg_t phase_cfg(input logic v_en, input logic h_en,
                                         input logic linked, input logic limited);
    ppu_cfg_t cfg;
    cfg.hsl_en        = h_en;
    cfg.hsl_thickness = 2'($urandom);
    cfg.hsl_str       = 4'($urandom);
    cfg.vsl_en        = v_en;
    cfg.vsl_thickness = 2'($urandom);
    cfg.vsl_str       = 4'($urandom);
    cfg.h2v_linked    = linked;
    cfg.limited_rgb   = limited;
    if (linked) begin
      cfg.vsl_thickness = ~cfg.hsl_thickness;
      cfg.vsl_str       = ~cfg.hsl_str;
    end
    return cfg;
  endfunction

  task automatic drive_random_pixel();
    @(negedge VCLK_Tx);
    pix_i.vsync    = 1'($urandom);
    pix_i.hsync    = 1'($urandom);
    pix_i.de       = ($urandom_range(0, 3) != 0);
    pix_i.red      = COLOR_W'($urandom);
    pix_i.green    = COLOR_W'($urandom);
    pix_i.blue     = COLOR_W'($urandom);
    pos_i.hpos_rel = POS_W'($urandom);
    pos_i.vpos_rel = POS_W'($urandom);
  endtask

  task automatic run_phase(input string name, input ppu_cfg_t cfg);
    @(negedge VCLK_Tx);
    cfg_i = cfg;
    $display("Phase %s, cfg %h", name, cfg);
    repeat (PHASE_PIXELS) drive_random_pixel();
  endtask

  // Reset in the middle of traffic, pixels keep coming
  task automatic pulse_reset();
    nVRST_Tx = 1'b0;
    repeat (RESET_CYCLES) drive_random_pixel();
    nVRST_Tx = 1'b1;
  endtask

  // ==================================================
  // Failure and timeout watch
  // ==================================================

  always @(negedge VCLK_Tx) begin
    if (UUT.asserts_u.fail_cnt != 0) begin
      $display("STATUS: FAIL");
      $fatal(1, "Assertion failed, stopping at the first error");
    end
  end

  always @(posedge VCLK_Tx) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("STATUS: FAIL");
      $fatal(1, "Timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
    end
  end

  // ==================================================
  // Main sequence
  // ==================================================

  initial begin
    void'($urandom(SEED));
    VCLK_Tx  = 1'b0;
    nVRST_Tx = 1'b0;
    pix_i    = '0;
    pos_i    = '0;
    cfg_i    = '0;
    repeat (RESET_CYCLES) @(negedge VCLK_Tx);
    nVRST_Tx = 1'b1;

    run_phase("passthrough", '0);
    run_phase("vert_only_a", phase_cfg(1'b1, 1'b0, 1'b0, 1'b0));
    run_phase("vert_only_b", phase_cfg(1'b1, 1'b0, 1'b0, 1'b0));
    run_phase("horiz_only_a", phase_cfg(1'b0, 1'b1, 1'b0, 1'b0));
    run_phase("horiz_only_b", phase_cfg(1'b0, 1'b1, 1'b0, 1'b0));
    run_phase("both_stages_a", phase_cfg(1'b1, 1'b1, 1'b0, 1'b0));
    run_phase("both_stages_b", phase_cfg(1'b1, 1'b1, 1'b0, 1'b0));
    run_phase("linked_vert", phase_cfg(1'b1, 1'b0, 1'b1, 1'b0));
    run_phase("linked_both", phase_cfg(1'b1, 1'b1, 1'b1, 1'b0));
    run_phase("limited_only", phase_cfg(1'b0, 1'b0, 1'b0, 1'b1));
    run_phase("limited_dimmed_a", phase_cfg(1'b1, 1'b1, 1'b0, 1'b1));
    run_phase("limited_dimmed_b", phase_cfg(1'b1, 1'b1, 1'b0, 1'b1));
    run_phase("limited_linked", phase_cfg(1'b1, 1'b0, 1'b1, 1'b1));
    run_phase("mixed_a", phase_cfg(1'($urandom), 1'($urandom), 1'($urandom), 1'($urandom)));
    run_phase("mixed_b", phase_cfg(1'($urandom), 1'($urandom), 1'($urandom), 1'($urandom)));

    pulse_reset();
    run_phase("after_reset", phase_cfg(1'b1, 1'b1, 1'b0, 1'b1));

    // Let the last pixels reach the outputs
    repeat (PIPE_LATENCY + 2) @(negedge VCLK_Tx);

    if (UUT.asserts_u.fail_cnt != 0) begin
      $display("STATUS: FAIL");
      $fatal(1, "%0d assertion failures", UUT.asserts_u.fail_cnt);
    end else begin
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule
